//--- build.f
logic/mac_io_pkg.sv
logic/mac_addr_decode.sv
logic/mac_via.sv
logic/mac_scc_mouse.sv
logic/mac_bus_result.sv
logic/mac_io_top.sv
sim/mac_io_checker.sv
sim/mac_io_assertions.sv
sim/tb_mac_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_mac_io -o sim_mac_io

output=$(./obj_dir/sim_mac_io)
echo "$output"

if grep -q "Test passed" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- sim/tb_mac_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_io;

  typedef enum logic [1:0] {op_write, op_read, op_vsync, op_mouse} op_e;

  typedef struct packed {
    op_e                 op;
    logic [23:0]         addr;    // Byte address
    logic [15:0]         data;    // Write byte, or external read word
    logic [15:0]         exp_rd;
    logic [2:0]          ipl;     // Expected after the row settles
    mac_io_pkg::region_e region;
  } row_t;

  localparam logic [23:0] c_via_portb_addr = 24'hE00000; // Inputs sampled per row

  logic                   clk_cpu;
  logic                   reset;
  mac_io_pkg::word_addr_t addr;
  logic                   as_n, uds_n, lds_n, rw;
  logic [15:0]            wdata, ext_rdata;
  logic                   vsync, hsync, mouse_x1, mouse_y1, mouse_x2, mouse_y2, mouse_btn;
  logic [15:0]            rdata;
  logic [2:0]             ipl_n;
  mac_io_pkg::region_e    region;
  logic [23:0]            ram_addr;
  logic                   chk_rdata, chk_ipl, chk_ram;
  logic [15:0]            exp_rdata;
  logic [2:0]             exp_ipl;
  mac_io_pkg::region_e    exp_region;
  logic [23:0]            exp_ram_addr;
  int                     data_errs, ipl_errs, decode_errs;
  int                     assert_errs;
  logic [23:0]            lfsr;
  row_t                   rows[$];
  logic                   table_ready;

  always #4 clk_cpu = ~clk_cpu; // 8 ns period

  mac_io_top #(.c_frames_per_sec(4)) mac_io_top_i (
    .clk_cpu (clk_cpu), .reset (reset), .i_addr (addr), .i_as_n (as_n),
    .i_uds_n (uds_n), .i_lds_n (lds_n), .i_rw (rw), .i_wdata (wdata),
    .i_ext_rdata (ext_rdata), .i_vsync (vsync), .i_hsync (hsync),
    .i_mouse_x1 (mouse_x1), .i_mouse_y1 (mouse_y1), .i_mouse_x2 (mouse_x2),
    .i_mouse_y2 (mouse_y2), .i_mouse_button (mouse_btn), .o_rdata (rdata),
    .o_ipl_n (ipl_n), .o_region (region), .o_ram_addr (ram_addr)
  );

  mac_io_checker mac_io_checker_i (
    .clk_cpu (clk_cpu), .i_chk_rdata (chk_rdata), .i_exp_rdata (exp_rdata),
    .i_rdata (rdata), .i_chk_ipl (chk_ipl), .i_exp_ipl (exp_ipl), .i_ipl_n (ipl_n),
    .i_exp_region (exp_region), .i_region (region), .i_chk_ram (chk_ram),
    .i_exp_ram_addr (exp_ram_addr), .i_ram_addr (ram_addr),
    .o_data_errs (data_errs), .o_ipl_errs (ipl_errs), .o_decode_errs (decode_errs)
  );

  // Fibonacci LFSR, taps 24 23 22 17
  function automatic logic [23:0] lfsr_next(input logic [23:0] s);
    return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  // RAM shows at 0 with ROM moved away, else at 0x600000
  function automatic logic [23:0] ram_offset(input logic [23:0] a);
    if (a[23:22] == 2'b00) return a;
    return a - 24'h600000;
  endfunction

  // Port B: H4 at bit 6, mouse Y2, X2 and button below, outputs still at reset 1s
  function automatic logic [15:0] portb_word();
    return {1'b1, ~hsync, mouse_y2, mouse_x2, mouse_btn, 3'b111, 8'hEF};
  endfunction

  task automatic add_row(input op_e op, input logic [23:0] a, input logic [15:0] d,
                         input logic [15:0] rd, input logic [2:0] ipl,
                         input mac_io_pkg::region_e rg);
    rows.push_back('{op, a, d, rd, ipl, rg});
  endtask

  task automatic release_bus();
    as_n      = 1'b1;
    uds_n     = 1'b1;
    lds_n     = 1'b1;
    rw        = 1'b1;
    chk_rdata = 1'b0;
    chk_ram   = 1'b0;
  endtask

  // Access cycle, two idle cycles, IPL checked in the second
  task automatic apply_row(input row_t r);
    @(posedge clk_cpu);
    #1;
    take_bit(mouse_x2);
    take_bit(mouse_y2);
    take_bit(mouse_btn);
    take_bit(hsync);
    case (r.op)
      op_write, op_read: begin
        addr  = r.addr[23:1];
        as_n  = 1'b0;
        uds_n = 1'b0;
        lds_n = 1'b0;
        rw    = (r.op == op_read);
        wdata = (r.op == op_read) ? 16'h0000 : {r.data[7:0], 8'h00};
        if (r.op == op_read) begin
          ext_rdata    = r.data;
          chk_rdata    = 1'b1;
          exp_rdata    = r.exp_rd;
          if (r.addr == c_via_portb_addr) exp_rdata = portb_word(); // Random input lines
          exp_region   = r.region;
          chk_ram      = (r.region == mac_io_pkg::region_ram);
          exp_ram_addr = ram_offset(r.addr);
        end
      end
      op_vsync: vsync = 1'b1;
      default:  mouse_x1 = ~mouse_x1; // Mouse toggle
    endcase
    @(posedge clk_cpu);
    #1;
    release_bus();
    vsync = 1'b0; // Fall seen at the next edge
    @(posedge clk_cpu);
    #1;
    chk_ipl = 1'b1;
    exp_ipl = r.ipl;
    @(posedge clk_cpu);
    #1;
    chk_ipl = 1'b0;
  endtask

  // ====================
  // Stimulus table
  // ====================
  task automatic build_table();
    // Decode map, ROM at 0 after reset
    add_row(op_read, 24'h000100, 16'h1234, 16'h1234, 3'b111, mac_io_pkg::region_rom);
    add_row(op_read, 24'h400200, 16'h5678, 16'h5678, 3'b111, mac_io_pkg::region_rom);
    add_row(op_read, 24'h420000, 16'h1111, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'h600400, 16'h9ABC, 16'h9ABC, 3'b111, mac_io_pkg::region_ram);
    add_row(op_read, 24'h580000, 16'h0F0F, 16'h0F0F, 3'b111, mac_io_pkg::region_scsi);
    add_row(op_read, 24'hD00000, 16'hCAFE, 16'hCAFE, 3'b111, mac_io_pkg::region_iwm);
    add_row(op_read, 24'h900000, 16'h0000, 16'h44EF, 3'b111, mac_io_pkg::region_scc);
    add_row(op_read, 24'hE01600, 16'h0000, 16'h00EF, 3'b111, mac_io_pkg::region_via);
    add_row(op_read, 24'h700000, 16'h2222, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'hF00000, 16'h3333, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'hE01E00, 16'h006F, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'h000100, 16'h4444, 16'h4444, 3'b111, mac_io_pkg::region_ram);
    add_row(op_read, 24'h600400, 16'h5555, 16'h0000, 3'b111, mac_io_pkg::region_none);
    // VIA round trips, byte plus pad
    add_row(op_write, 24'hE00800, 16'h0034, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'hE00800, 16'h0000, 16'h34EF, 3'b111, mac_io_pkg::region_via);
    add_row(op_write, 24'hE00E00, 16'h00A5, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'hE00E00, 16'h0000, 16'hA5EF, 3'b111, mac_io_pkg::region_via);
    add_row(op_write, 24'hE01600, 16'h0040, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'hE01600, 16'h0000, 16'h40EF, 3'b111, mac_io_pkg::region_via);
    add_row(op_write, 24'hE01400, 16'h005A, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'hE01400, 16'h0000, 16'h5AEF, 3'b111, mac_io_pkg::region_via);
    add_row(op_read, 24'hE01E00, 16'h0000, 16'h6FEF, 3'b111, mac_io_pkg::region_via);
    // Port B, word built from the lines taken for this row
    add_row(op_read, c_via_portb_addr, 16'h0000, 16'h0000, 3'b111, mac_io_pkg::region_via);
    // IER set, set, clear
    add_row(op_write, 24'hE01C00, 16'h0082, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'hE01C00, 16'h0081, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'hE01C00, 16'h0002, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'hE01C00, 16'h0000, 16'h01EF, 3'b111, mac_io_pkg::region_via);
    add_row(op_write, 24'hE01C00, 16'h007F, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'hE01C00, 16'h0082, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_read, 24'hE01C00, 16'h0000, 16'h02EF, 3'b111, mac_io_pkg::region_via);
    // VBLANK, then one-second on the fourth fall
    add_row(op_vsync, 24'h000000, 16'h0000, 16'h0000, 3'b110, mac_io_pkg::region_none);
    add_row(op_read, 24'hE01A00, 16'h0000, 16'h82EF, 3'b110, mac_io_pkg::region_via);
    add_row(op_read, 24'hE01E00, 16'h0000, 16'h6FEF, 3'b111, mac_io_pkg::region_via);
    add_row(op_vsync, 24'h000000, 16'h0000, 16'h0000, 3'b110, mac_io_pkg::region_none);
    add_row(op_vsync, 24'h000000, 16'h0000, 16'h0000, 3'b110, mac_io_pkg::region_none);
    add_row(op_vsync, 24'h000000, 16'h0000, 16'h0000, 3'b110, mac_io_pkg::region_none);
    add_row(op_read, 24'hE01A00, 16'h0000, 16'h83EF, 3'b110, mac_io_pkg::region_via);
    add_row(op_read, 24'hE01E00, 16'h0000, 16'h6FEF, 3'b111, mac_io_pkg::region_via);
    add_row(op_read, 24'hE01A00, 16'h0000, 16'h00EF, 3'b111, mac_io_pkg::region_via);
    // SCC channel A: WR15 bit 3, WR1 bit 0, WR9 bit 3
    add_row(op_write, 24'h900002, 16'h000F, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h0008, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h0001, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h0001, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h0009, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h0008, 16'h0000, 3'b111, mac_io_pkg::region_none);
    add_row(op_mouse, 24'h000000, 16'h0000, 16'h0000, 3'b101, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h0003, 16'h0000, 3'b101, mac_io_pkg::region_none);
    add_row(op_read, 24'h900002, 16'h0000, 16'h08EF, 3'b101, mac_io_pkg::region_scc);
    add_row(op_read, 24'h900002, 16'h0000, 16'h4CEF, 3'b101, mac_io_pkg::region_scc);
    add_row(op_write, 24'h900002, 16'h0010, 16'h0000, 3'b111, mac_io_pkg::region_none);
    // Both pending, then WR9 hardware reset
    add_row(op_mouse, 24'h000000, 16'h0000, 16'h0000, 3'b101, mac_io_pkg::region_none);
    add_row(op_vsync, 24'h000000, 16'h0000, 16'h0000, 3'b110, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h0009, 16'h0000, 3'b110, mac_io_pkg::region_none);
    add_row(op_write, 24'h900002, 16'h00C0, 16'h0000, 3'b110, mac_io_pkg::region_none);
    add_row(op_read, 24'hE01E00, 16'h0000, 16'h6FEF, 3'b111, mac_io_pkg::region_via);
  endtask

  // Watchdog, 20 cycles per row
  initial begin
    wait (table_ready);
    repeat (rows.size() * 20 + 20) @(posedge clk_cpu);
    $display("Watchdog expired before the stimulus table finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    clk_cpu     = 1'b0;
    reset       = 1'b1;
    addr        = '0;
    wdata       = '0;
    ext_rdata   = '0;
    vsync       = 1'b0;
    hsync       = 1'b0;
    mouse_x1    = 1'b0;
    mouse_y1    = 1'b0;
    mouse_x2    = 1'b0;
    mouse_y2    = 1'b0;
    mouse_btn   = 1'b0;
    chk_ipl     = 1'b0;
    exp_ipl     = 3'b111;
    exp_rdata   = '0;
    exp_region  = mac_io_pkg::region_none;
    exp_ram_addr = '0;
    lfsr        = 24'd99297;
    table_ready = 1'b0;
    release_bus();
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk_cpu);
    #1;
    reset = 1'b0;
    foreach (rows[i]) apply_row(rows[i]);
    @(posedge clk_cpu);
    assert_errs = mac_io_top_i.mac_io_assertions_i.failures;
    $display("Errors: data %0d, ipl %0d, decode %0d, assertion %0d", data_errs, ipl_errs,
             decode_errs, assert_errs);
    if (data_errs + ipl_errs + decode_errs + assert_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/mac_io_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mac_io_assertions (
  input wire       clk_cpu,
  input wire       reset,
  input wire [2:0] i_ipl_n,
  input wire       i_via_irq,
  input wire       i_scc_irq
);

  int failures = 0; // Failed assertion count

  // Flags, enables and WR9 all clear out of reset
  ipl_idle_after_reset: assert property (@(posedge clk_cpu)
    reset |=> (i_ipl_n == 3'b111))
    else begin
      $error("IPL lines not idle after reset");
      failures = failures + 1;
    end

  via_wins: assert property (@(posedge clk_cpu) disable iff (reset)
    i_via_irq |-> (i_ipl_n == 3'b110))
    else begin
      $error("VIA interrupt did not win priority");
      failures = failures + 1;
    end

  scc_level: assert property (@(posedge clk_cpu) disable iff (reset)
    (!i_via_irq && i_scc_irq) |-> (i_ipl_n == 3'b101))
    else begin
      $error("SCC interrupt alone did not give level 2");
      failures = failures + 1;
    end

endmodule

// Top level holds the clock next to the result block's signals
bind mac_io_top mac_io_assertions mac_io_assertions_i (
  .clk_cpu   (clk_cpu),
  .reset     (reset),
  .i_ipl_n   (o_ipl_n),
  .i_via_irq (via_irq),
  .i_scc_irq (scc_irq)
);

`default_nettype wire

//--- sim/mac_io_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mac_io_checker (
  input  wire                      clk_cpu,
  input  wire                      i_chk_rdata,   // Read cycle in progress
  input  wire [15:0]               i_exp_rdata,
  input  wire [15:0]               i_rdata,
  input  wire                      i_chk_ipl,
  input  wire [2:0]                i_exp_ipl,
  input  wire [2:0]                i_ipl_n,
  input  wire mac_io_pkg::region_e i_exp_region,
  input  wire mac_io_pkg::region_e i_region,
  input  wire                      i_chk_ram,     // Only for RAM reads
  input  wire [23:0]               i_exp_ram_addr,
  input  wire [23:0]               i_ram_addr,
  output int                       o_data_errs,
  output int                       o_ipl_errs,
  output int                       o_decode_errs
);

  initial begin
    o_data_errs   = 0;
    o_ipl_errs    = 0;
    o_decode_errs = 0;
  end

  // Falling edge, half a cycle after the drive
  always @(negedge clk_cpu) begin
    if (i_chk_rdata && (i_rdata !== i_exp_rdata)) begin
      o_data_errs = o_data_errs + 1;
      $display("error at %0t: o_rdata expected %h, got %h", $time, i_exp_rdata, i_rdata);
    end
    if (i_chk_rdata && (i_region !== i_exp_region)) begin // Decode goes with every read
      o_decode_errs = o_decode_errs + 1;
      $display("error at %0t: o_region expected %0d, got %0d", $time, i_exp_region,
               i_region);
    end
    if (i_chk_ram && (i_ram_addr !== i_exp_ram_addr)) begin
      o_decode_errs = o_decode_errs + 1;
      $display("error at %0t: o_ram_addr expected %h, got %h", $time, i_exp_ram_addr,
               i_ram_addr);
    end
    if (i_chk_ipl && (i_ipl_n !== i_exp_ipl)) begin
      o_ipl_errs = o_ipl_errs + 1;
      $display("error at %0t: o_ipl_n expected %b, got %b", $time, i_exp_ipl, i_ipl_n);
    end
  end

endmodule

`default_nettype wire

//--- logic/mac_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac_io_top #(
  parameter int c_frames_per_sec = 60
) (
  input  wire                         clk_cpu,
  input  wire                         reset,
  // 68000 bus
  input  wire mac_io_pkg::word_addr_t i_addr,
  input  wire                         i_as_n,
  input  wire                         i_uds_n,
  input  wire                         i_lds_n,
  input  wire                         i_rw,         // 1 read
  input  wire [15:0]                  i_wdata,
  input  wire [15:0]                  i_ext_rdata,
  // Video timing and mouse lines
  input  wire                         i_vsync,
  input  wire                         i_hsync,
  input  wire                         i_mouse_x1,
  input  wire                         i_mouse_y1,
  input  wire                         i_mouse_x2,
  input  wire                         i_mouse_y2,
  input  wire                         i_mouse_button,
  output logic [15:0]                 o_rdata,
  output logic [2:0]                  o_ipl_n,
  output mac_io_pkg::region_e         o_region,
  output logic [23:0]                 o_ram_addr
);

  logic       via_cs;
  logic       scc_cs;
  logic       overlay;
  logic [7:0] via_rdata;
  logic       via_irq;
  logic [7:0] scc_rdata;
  logic       scc_irq;

  mac_addr_decode mac_addr_decode_i (
    .i_addr     (i_addr),
    .i_as_n     (i_as_n),
    .i_overlay  (overlay),
    .o_region   (o_region),
    .o_via_cs   (via_cs),
    .o_scc_cs   (scc_cs),
    .o_ram_addr (o_ram_addr)
  );

  mac_via #(
    .c_frames_per_sec (c_frames_per_sec)
  ) mac_via_i (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_via_cs       (via_cs),
    .i_reg          (mac_io_pkg::via_reg_e'(i_addr[12:9])),
    .i_rw           (i_rw),
    .i_uds_n        (i_uds_n),
    .i_wdata_hi     (i_wdata[15:8]),
    .i_vsync        (i_vsync),
    .i_hsync        (i_hsync),
    .i_mouse_x2     (i_mouse_x2),
    .i_mouse_y2     (i_mouse_y2),
    .i_mouse_button (i_mouse_button),
    .i_scc_wreq     (1'b0),          // SCC wait/request line not brought out here
    .o_via_rdata    (via_rdata),
    .o_via_irq      (via_irq),
    .o_overlay      (overlay)
  );

  mac_scc_mouse mac_scc_mouse_i (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_scc_cs    (scc_cs),
    .i_as_n      (i_as_n),
    .i_rs        (i_addr[2:1]),   // Channel and control/data
    .i_rw        (i_rw),
    .i_uds_n     (i_uds_n),
    .i_lds_n     (i_lds_n),
    .i_wdata_hi  (i_wdata[15:8]),
    .i_mouse_x1  (i_mouse_x1),
    .i_mouse_y1  (i_mouse_y1),
    .o_scc_rdata (scc_rdata),
    .o_scc_irq   (scc_irq)
  );

  mac_bus_result mac_bus_result_i (
    .i_region    (o_region),
    .i_uds_n     (i_uds_n),
    .i_lds_n     (i_lds_n),
    .i_via_rdata (via_rdata),
    .i_scc_rdata (scc_rdata),
    .i_ext_rdata (i_ext_rdata),
    .i_via_irq   (via_irq),
    .i_scc_irq   (scc_irq),
    .o_rdata     (o_rdata),
    .o_ipl_n     (o_ipl_n)
  );

endmodule

`default_nettype wire

//--- logic/mac_bus_result.sv
`timescale 1ns/1ps
`default_nettype none

module mac_bus_result (
  input  wire mac_io_pkg::region_e i_region,
  input  wire                      i_uds_n,
  input  wire                      i_lds_n,
  input  wire [7:0]                i_via_rdata,
  input  wire [7:0]                i_scc_rdata,
  input  wire [15:0]               i_ext_rdata,  // ROM, RAM, IWM and SCSI
  input  wire                      i_via_irq,
  input  wire                      i_scc_irq,
  output logic [15:0]              o_rdata,
  output logic [2:0]               o_ipl_n       // {IPL2, IPL1, IPL0}, active low
);

  // ====================
  // CPU read data
  // ====================
  always_comb begin
    case (i_region)
      mac_io_pkg::region_via: o_rdata = {i_via_rdata, mac_io_pkg::c_pad_byte};
      mac_io_pkg::region_scc: begin
        if (!i_uds_n || !i_lds_n) o_rdata = {i_scc_rdata, mac_io_pkg::c_pad_byte};
        else                      o_rdata = 16'h0000; // No strobe, no SCC cycle
      end
      mac_io_pkg::region_rom,
      mac_io_pkg::region_ram,
      mac_io_pkg::region_iwm,
      mac_io_pkg::region_scsi: o_rdata = i_ext_rdata;
      default:                 o_rdata = 16'h0000; // Unmapped
    endcase
  end

  // ====================
  // Interrupt priority
  // ====================
  always_comb begin
    if (i_via_irq)      o_ipl_n = 3'b110; // Level 1
    else if (i_scc_irq) o_ipl_n = 3'b101; // Level 2
    else                o_ipl_n = 3'b111;
  end

endmodule

`default_nettype wire

//--- logic/mac_scc_mouse.sv
`timescale 1ns/1ps
`default_nettype none

module mac_scc_mouse (
  input  wire       clk_cpu,
  input  wire       reset,
  input  wire       i_scc_cs,
  input  wire       i_as_n,
  input  wire [1:0] i_rs,        // Bit 0 channel A, bit 1 data
  input  wire       i_rw,
  input  wire       i_uds_n,
  input  wire       i_lds_n,
  input  wire [7:0] i_wdata_hi,
  input  wire       i_mouse_x1,  // DCD A
  input  wire       i_mouse_y1,  // DCD B
  output logic [7:0] o_scc_rdata,
  output logic       o_scc_irq
);

  logic       scc8_cs;
  logic       wreg_a;
  logic       wreg_b;
  logic       wr9_cmd;
  logic       hw_reset;
  logic       chan_a_rst;
  logic       chan_b_rst;
  logic       reset_scc;
  logic       ext_reset_a;
  logic       ext_reset_b;
  logic       do_latch_a;
  logic       do_latch_b;
  logic [3:0] rindex;        // Current register pointer
  logic [3:0] rindex_next;   // Applied once the cycle ends
  logic [5:0] wr9;           // Bit 3 master interrupt enable
  logic [7:0] wr1_a, wr1_b;  // Bit 0 external interrupt enable
  logic [7:0] wr15_a, wr15_b;
  logic       latch_open_a, latch_open_b;
  logic       dcd_latch_a, dcd_latch_b;
  logic       ip_a, ip_b;    // External interrupt pending
  logic [2:0] vec_stat;

  // ====================
  // Write decode
  // ====================
  assign scc8_cs = i_scc_cs && (!i_uds_n || !i_lds_n);
  assign wreg_a  = scc8_cs && !i_rw && !i_rs[1] && i_rs[0];
  assign wreg_b  = scc8_cs && !i_rw && !i_rs[1] && !i_rs[0];
  assign wr9_cmd = (wreg_a || wreg_b) && (rindex == 4'd9);

  assign hw_reset   = wr9_cmd && (i_wdata_hi[7:6] == 2'b11);
  assign chan_a_rst = hw_reset || (wr9_cmd && (i_wdata_hi[7:6] == 2'b10));
  assign chan_b_rst = hw_reset || (wr9_cmd && (i_wdata_hi[7:6] == 2'b01));
  assign reset_scc  = reset || hw_reset;

  // Command 0x10 in WR0
  assign ext_reset_a = wreg_a && (rindex == 4'd0) && (i_wdata_hi[5:3] == 3'b010);
  assign ext_reset_b = wreg_b && (rindex == 4'd0) && (i_wdata_hi[5:3] == 3'b010);

  // Level change against the latch while DCD is enabled
  assign do_latch_a = latch_open_a && wr15_a[3] && (i_mouse_x1 != dcd_latch_a);
  assign do_latch_b = latch_open_b && wr15_b[3] && (i_mouse_y1 != dcd_latch_b);

  assign o_scc_irq = wr9[3] && (ip_a || ip_b);

  // WR1 and WR9
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      wr9   <= '0;
      wr1_a <= '0;
      wr1_b <= '0;
    end else begin
      if (wr9_cmd) wr9 <= i_wdata_hi[5:0];
      if (chan_a_rst) wr1_a <= {2'b00, wr1_a[5], 2'b00, wr1_a[2], 2'b00}; // Keep 5 and 2
      else if (wreg_a && rindex == 4'd1) wr1_a <= i_wdata_hi;
      if (chan_b_rst) wr1_b <= {2'b00, wr1_b[5], 2'b00, wr1_b[2], 2'b00};
      else if (wreg_b && rindex == 4'd1) wr1_b <= i_wdata_hi;
    end
  end

  // ====================
  // Pointer, WR15, DCD
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (reset_scc) begin
      rindex       <= '0;
      rindex_next  <= '0;
      wr15_a       <= mac_io_pkg::c_scc_wr15_reset;
      wr15_b       <= mac_io_pkg::c_scc_wr15_reset;
      latch_open_a <= 1'b1;
      latch_open_b <= 1'b1;
      dcd_latch_a  <= 1'b0;
      dcd_latch_b  <= 1'b0;
      ip_a         <= 1'b0;
      ip_b         <= 1'b0;
    end else begin
      if (i_as_n) rindex <= rindex_next; // Pointer moves between cycles
      if (scc8_cs && !i_rs[1]) begin
        rindex_next <= '0;               // Any control access returns to 0
        if (!i_rw && rindex == 4'd0) begin
          rindex_next <= {i_wdata_hi[5:3] == 3'b001, i_wdata_hi[2:0]}; // Point high cmd
        end
      end
      if (rindex == 4'd15) begin
        if (wreg_a) wr15_a <= i_wdata_hi;
        if (wreg_b) wr15_b <= i_wdata_hi;
      end

      if (ext_reset_a) begin  // Reopen and ack
        latch_open_a <= 1'b1;
        ip_a         <= 1'b0;
      end else if (do_latch_a) begin
        latch_open_a <= 1'b0;
        if (wr1_a[0]) ip_a <= 1'b1;
      end
      if (ext_reset_b) begin
        latch_open_b <= 1'b1;
        ip_b         <= 1'b0;
      end else if (do_latch_b) begin
        latch_open_b <= 1'b0;
        if (wr1_b[0]) ip_b <= 1'b1;
      end
      if (do_latch_a) dcd_latch_a <= i_mouse_x1;
      if (do_latch_b) dcd_latch_b <= i_mouse_y1;
    end
  end

  // Status vector in RR2 B, channel A first
  assign vec_stat = ip_a ? 3'b101 : (ip_b ? 3'b001 : 3'b011);

  always_comb begin
    o_scc_rdata = 8'h00;
    case (rindex)
      4'd0: begin // RR0, DCD shows the latched level while enabled
        if (i_rs[0]) o_scc_rdata = {4'b0100, wr15_a[3] ? dcd_latch_a : i_mouse_x1, 3'b100};
        else         o_scc_rdata = {4'b0100, wr15_b[3] ? dcd_latch_b : i_mouse_y1, 3'b100};
      end
      4'd2: if (!i_rs[0]) o_scc_rdata = {4'b0000, vec_stat, 1'b0};
      4'd3: if (i_rs[0])  o_scc_rdata = {4'b0000, ip_a, 2'b00, ip_b}; // RR3 A only
      default: o_scc_rdata = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/mac_via.sv
`timescale 1ns/1ps
`default_nettype none

module mac_via #(
  parameter int c_frames_per_sec = 60 // VBLANKs per one-second tick
) (
  input  wire                       clk_cpu,
  input  wire                       reset,
  input  wire                       i_via_cs,
  input  wire mac_io_pkg::via_reg_e i_reg,
  input  wire                       i_rw,
  input  wire                       i_uds_n,
  input  wire [7:0]                 i_wdata_hi,
  input  wire                       i_vsync,
  input  wire                       i_hsync,
  input  wire                       i_mouse_x2,
  input  wire                       i_mouse_y2,
  input  wire                       i_mouse_button,
  input  wire                       i_scc_wreq,
  output logic [7:0]                o_via_rdata,
  output logic                      o_via_irq,
  output logic                      o_overlay
);

  localparam int c_cnt_w = $clog2(c_frames_per_sec + 1);

  logic [7:0]         porta_out;   // Port A output latch
  logic [7:0]         portb_out;   // Port B output latch
  logic               b0_ddr;      // RTC data direction
  logic [7:0]         acr;
  logic [6:0]         ifr;
  logic [6:0]         ier;
  logic [15:0]        t1_count;
  logic [15:0]        t1_latch;
  logic [15:0]        t2_count;
  logic [7:0]         t2_latch_lo; // Waits for the high byte
  logic [7:0]         sr;
  logic               vsync_q;
  logic [c_cnt_w-1:0] frame_cnt;
  logic               wr_en;
  logic               rd_en;
  logic               vsync_fall;

  // VIA sits on the upper data byte
  assign wr_en      = i_via_cs && !i_uds_n && !i_rw;
  assign rd_en      = i_via_cs && !i_uds_n && i_rw;
  assign vsync_fall = vsync_q && !i_vsync;

  assign o_via_irq = |(ifr & ier);
  assign o_overlay = ~porta_out[4];

  // ====================
  // Control registers
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      porta_out <= mac_io_pkg::c_via_porta_reset;
      portb_out <= mac_io_pkg::c_via_portb_reset;
      b0_ddr    <= 1'b1;
      acr       <= '0;
      ifr       <= '0;
      ier       <= '0;
      vsync_q   <= 1'b0;
      frame_cnt <= '0;
    end else begin
      if (wr_en) begin
        case (i_reg)
          mac_io_pkg::via_portb: portb_out <= i_wdata_hi;
          mac_io_pkg::via_ddrb:  b0_ddr    <= i_wdata_hi[0];
          mac_io_pkg::via_t2_hi: ifr[mac_io_pkg::int_t2] <= 1'b0; // Reload acks timer 2
          mac_io_pkg::via_sr: begin
            if (acr[4:2] == 3'b111) ifr[mac_io_pkg::int_keyready] <= 1'b1; // Shift out done
          end
          mac_io_pkg::via_acr:   acr <= i_wdata_hi;
          mac_io_pkg::via_ifr:   ifr <= ifr & ~i_wdata_hi[6:0]; // Write 1 to clear
          mac_io_pkg::via_ier: begin
            if (i_wdata_hi[7]) ier <= ier | i_wdata_hi[6:0];   // Bit 7 picks set or clear
            else               ier <= ier & ~i_wdata_hi[6:0];
          end
          mac_io_pkg::via_porta: porta_out <= i_wdata_hi;
          default: ;
        endcase
      end else if (rd_en) begin
        case (i_reg) // Read side effects
          mac_io_pkg::via_portb: begin
            ifr[mac_io_pkg::int_keyclk] <= 1'b0;
            ifr[mac_io_pkg::int_keybit] <= 1'b0;
          end
          mac_io_pkg::via_t2_lo: ifr[mac_io_pkg::int_t2]       <= 1'b0;
          mac_io_pkg::via_sr:    ifr[mac_io_pkg::int_keyready] <= 1'b0;
          mac_io_pkg::via_porta: begin
            ifr[mac_io_pkg::int_onesec] <= 1'b0;
            ifr[mac_io_pkg::int_vblank] <= 1'b0;
          end
          default: ;
        endcase
      end

      // Frame timing, set beats a clearing read
      vsync_q <= i_vsync;
      if (vsync_fall) begin
        ifr[mac_io_pkg::int_vblank] <= 1'b1;
        if (frame_cnt == c_cnt_w'(c_frames_per_sec - 1)) begin
          ifr[mac_io_pkg::int_onesec] <= 1'b1;
          frame_cnt <= '0;
        end else begin
          frame_cnt <= frame_cnt + 1'b1;
        end
      end
    end
  end

  // ====================
  // Timers and shift reg
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (wr_en) begin
      case (i_reg)
        mac_io_pkg::via_t1c_lo: t1_count[7:0]  <= i_wdata_hi;
        mac_io_pkg::via_t1c_hi: t1_count[15:8] <= i_wdata_hi;
        mac_io_pkg::via_t1l_lo: t1_latch[7:0]  <= i_wdata_hi;
        mac_io_pkg::via_t1l_hi: t1_latch[15:8] <= i_wdata_hi;
        mac_io_pkg::via_t2_lo:  t2_latch_lo    <= i_wdata_hi;
        mac_io_pkg::via_t2_hi:  t2_count       <= {i_wdata_hi, t2_latch_lo}; // Full load
        mac_io_pkg::via_sr:     sr             <= i_wdata_hi;
        default: ;
      endcase
    end
  end

  // Read mux, selected further by the bus block
  always_comb begin
    case (i_reg)
      mac_io_pkg::via_portb:  o_via_rdata = {portb_out[7], ~i_hsync, i_mouse_y2, i_mouse_x2,
                                             i_mouse_button, portb_out[2:1],
                                             b0_ddr ? portb_out[0] : 1'b0};
      mac_io_pkg::via_ddrb:   o_via_rdata = {7'b1000011, b0_ddr};
      mac_io_pkg::via_ddra:   o_via_rdata = 8'h7F;
      mac_io_pkg::via_t1c_lo: o_via_rdata = t1_count[7:0];
      mac_io_pkg::via_t1c_hi: o_via_rdata = t1_count[15:8];
      mac_io_pkg::via_t1l_lo: o_via_rdata = t1_latch[7:0];
      mac_io_pkg::via_t1l_hi: o_via_rdata = t1_latch[15:8];
      mac_io_pkg::via_t2_lo:  o_via_rdata = t2_count[7:0];
      mac_io_pkg::via_t2_hi:  o_via_rdata = t2_count[15:8];
      mac_io_pkg::via_sr:     o_via_rdata = sr;
      mac_io_pkg::via_acr:    o_via_rdata = acr;
      mac_io_pkg::via_pcr:    o_via_rdata = 8'h00;
      mac_io_pkg::via_ifr:    o_via_rdata = {o_via_irq, ifr}; // Bit 7 is any enabled pending
      mac_io_pkg::via_ier:    o_via_rdata = {1'b0, ier};
      mac_io_pkg::via_porta:  o_via_rdata = {i_scc_wreq, porta_out[6:0]};
      default:                o_via_rdata = 8'hBE;            // Unused select 1
    endcase
  end

endmodule

`default_nettype wire

//--- logic/mac_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mac_addr_decode (
  input  wire mac_io_pkg::word_addr_t i_addr,
  input  wire                         i_as_n,
  input  wire                         i_overlay,  // High once ROM leaves address 0
  output mac_io_pkg::region_e         o_region,
  output logic                        o_via_cs,
  output logic                        o_scc_cs,
  output logic [23:0]                 o_ram_addr  // Byte offset into RAM
);

  logic [23:0] ram_base;

  // ====================
  // Region map
  // ====================
  always_comb begin
    o_region = mac_io_pkg::region_none;
    if (!i_as_n) begin // Nothing selected between cycles
      casez (i_addr[23:20])
        4'b00??: begin
          if (i_overlay) o_region = mac_io_pkg::region_ram;
          else           o_region = mac_io_pkg::region_rom; // Boot mapping
        end
        4'b0100: begin
          if (!i_addr[17]) o_region = mac_io_pkg::region_rom;
        end
        4'b0101: begin
          if (i_addr[19:12] == 8'h80) o_region = mac_io_pkg::region_scsi;
        end
        4'b0110: begin
          if (!i_overlay) o_region = mac_io_pkg::region_ram; // RAM shadow at 0x600000
        end
        4'b10?1: o_region = mac_io_pkg::region_scc;  // 0x9 and 0xB
        4'b1101: o_region = mac_io_pkg::region_iwm;
        4'b1110: o_region = mac_io_pkg::region_via;
        default: o_region = mac_io_pkg::region_none;
      endcase
    end
  end

  assign o_via_cs = (o_region == mac_io_pkg::region_via);
  assign o_scc_cs = (o_region == mac_io_pkg::region_scc);

  // RAM sits at 0 once overlay is lifted, else at the normal base
  assign ram_base   = i_overlay ? 24'h000000 : mac_io_pkg::c_ram_base_normal;
  assign o_ram_addr = {i_addr, 1'b0} - ram_base;

endmodule

`default_nettype wire

//--- logic/mac_io_pkg.sv
`default_nettype none

package mac_io_pkg;

  // ====================
  // Address map
  // ====================
  typedef logic [23:1] word_addr_t; // CPU word address, A0 comes from the strobes

  // Decoded target of a bus cycle
  typedef enum logic [2:0] {
    region_none,
    region_rom,
    region_ram,
    region_scsi,
    region_scc,
    region_iwm,
    region_via
  } region_e;

  localparam logic [23:0] c_ram_base_normal = 24'h600000; // RAM while ROM sits at 0

  // ====================
  // VIA
  // ====================
  // Register select, word address bits 12 to 9
  typedef enum logic [3:0] {
    via_portb    = 4'h0,
    via_ddrb     = 4'h2,
    via_ddra     = 4'h3,
    via_t1c_lo   = 4'h4,
    via_t1c_hi   = 4'h5,
    via_t1l_lo   = 4'h6,
    via_t1l_hi   = 4'h7,
    via_t2_lo    = 4'h8,
    via_t2_hi    = 4'h9,
    via_sr       = 4'hA,
    via_acr      = 4'hB,
    via_pcr      = 4'hC,
    via_ifr      = 4'hD,
    via_ier      = 4'hE,
    via_porta    = 4'hF
  } via_reg_e;

  // IFR and IER bit positions
  typedef enum logic [2:0] {
    int_onesec   = 3'd0,
    int_vblank   = 3'd1,
    int_keyready = 3'd2,
    int_keybit   = 3'd3,
    int_keyclk   = 3'd4,
    int_t2       = 3'd5,
    int_t1       = 3'd6
  } int_bit_e;

  localparam logic [7:0] c_via_porta_reset = 8'h7F; // Bit 4 set, ROM mirrored at 0
  localparam logic [7:0] c_via_portb_reset = 8'hFF;

  // ====================
  // SCC and bus
  // ====================
  localparam logic [7:0] c_scc_wr15_reset = 8'hF8; // DCD enable (bit 3) set
  localparam logic [7:0] c_pad_byte       = 8'hEF; // Low byte of 8-bit peripheral reads

endpackage

`default_nettype wire
